// File: hdl/io_map_pkg.sv
package io_map_pkg;

	typedef logic [15:0] io_addr_t;
	typedef logic [21:0] dev_sel_t;

	// bit positions in dev_sel_t
	localparam int sel_hdd0       = 0;
	localparam int sel_hdd1       = 1;
	localparam int sel_floppy     = 2;
	localparam int sel_joy        = 3;
	localparam int sel_dma_master = 4;
	localparam int sel_dma_page   = 5;
	localparam int sel_dma_slave  = 6;
	localparam int sel_pic_master = 7;
	localparam int sel_pic_slave  = 8;
	localparam int sel_pit        = 9;
	localparam int sel_ps2_io     = 10;
	localparam int sel_ps2_ctl    = 11;
	localparam int sel_rtc        = 12;
	localparam int sel_fm         = 13;
	localparam int sel_sb         = 14;
	localparam int sel_uart       = 15;
	localparam int sel_mpu        = 16;
	localparam int sel_vga_b      = 17;
	localparam int sel_vga_c      = 18;
	localparam int sel_vga_d      = 19;
	localparam int sel_pci        = 20;
	localparam int sel_sysctl     = 21;

	localparam io_addr_t hdd0_base       = 16'h01F0;
	localparam int       hdd0_ign        = 3;
	localparam io_addr_t hdd0_alt        = 16'h03F6;
	localparam io_addr_t hdd1_base       = 16'h0170;
	localparam int       hdd1_ign        = 3;
	localparam io_addr_t hdd1_alt        = 16'h0376;
	localparam io_addr_t joy_port        = 16'h0201;
	localparam io_addr_t floppy_base     = 16'h03F0;
	localparam int       floppy_ign      = 3;
	localparam io_addr_t dma_master_base = 16'h00C0;
	localparam int       dma_master_ign  = 5;
	localparam io_addr_t dma_page_base   = 16'h0080;
	localparam int       dma_page_ign    = 4;
	localparam io_addr_t dma_slave_base  = 16'h0000;
	localparam int       dma_slave_ign   = 4;
	localparam io_addr_t pic_master_base = 16'h0020;
	localparam io_addr_t pic_slave_base  = 16'h00A0;
	localparam int       pic_ign         = 1;
	localparam io_addr_t pit_base        = 16'h0040;
	localparam int       pit_ign         = 2;
	localparam io_addr_t pit_port_b      = 16'h0061; // speaker gate, shared with ps2 range
	localparam io_addr_t ps2_io_base     = 16'h0060;
	localparam int       ps2_io_ign      = 3;
	localparam io_addr_t ps2_ctl_base    = 16'h0090;
	localparam int       ps2_ctl_ign     = 4;
	localparam io_addr_t rtc_base        = 16'h0070;
	localparam int       rtc_ign         = 1;
	localparam io_addr_t fm_base         = 16'h0388;
	localparam int       fm_ign          = 2;
	localparam io_addr_t sb_base         = 16'h0220;
	localparam int       sb_ign          = 4;
	localparam io_addr_t uart_base       = 16'h03F8;
	localparam int       uart_ign        = 3;
	localparam io_addr_t mpu_base        = 16'h0330;
	localparam int       mpu_ign         = 1;
	localparam io_addr_t vga_b_base      = 16'h03B0;
	localparam io_addr_t vga_c_base      = 16'h03C0;
	localparam io_addr_t vga_d_base      = 16'h03D0;
	localparam int       vga_ign         = 4;
	localparam io_addr_t pci_cfg_addr    = 16'h0CF8;
	localparam io_addr_t pci_cfg_data    = 16'h0CFC;
	localparam io_addr_t sysctl_port     = 16'h8888;

	localparam int hdd_alt_bit = 9; // set on the 3x6 alternate ports

endpackage

// File: hdl/bus_types_pkg.sv
package bus_types_pkg;

	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  io_byte_t;
	typedef logic [2:0]  io_size_t; // bytes per transfer
	typedef logic [7:0]  syscfg_t;

	localparam syscfg_t  syscfg_reset_value = 8'hA2;
	localparam syscfg_t  syscfg_key         = 8'hA1; // expected in wdata[15:8]
	localparam io_size_t syscfg_write_size  = 3'd2;

endpackage

// File: hdl/io_cycle_if.sv
`timescale 1ns/1ps

interface io_cycle_if;
	import io_map_pkg::*;
	import bus_types_pkg::*;

	dev_sel_t sel;
	logic     rd;
	logic     wr;
	io_size_t size;
	io_data_t wdata;
	logic     io32;

	modport source (
		output sel,
		output rd,
		output wr,
		output size,
		output wdata,
		output io32
	);

	modport sink (
		input sel,
		input rd,
		input wr,
		input size,
		input wdata,
		input io32
	);

endinterface

// File: hdl/io_port_decode.sv
`timescale 1ns/1ps

module io_port_decode (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  io_map_pkg::io_addr_t    address,
	input  logic                    rd,
	input  logic                    wr,
	input  bus_types_pkg::io_size_t size,
	input  bus_types_pkg::io_data_t wdata,
	io_cycle_if.source              cyc
);
	import io_map_pkg::*;

	dev_sel_t sel_next;
	logic     io32_next;

	// match with the low ign bits ignored
	function automatic logic port_match(io_addr_t addr, io_addr_t base, int ign);
		io_addr_t mask;
		mask = {16{1'b1}} << ign;
		return (addr & mask) == base;
	endfunction

	always_comb begin
		sel_next = '0;
		sel_next[sel_hdd0] = port_match(address, hdd0_base, hdd0_ign) || address == hdd0_alt;
		sel_next[sel_hdd1] = port_match(address, hdd1_base, hdd1_ign) || address == hdd1_alt;
		sel_next[sel_floppy] = port_match(address, floppy_base, floppy_ign);
		sel_next[sel_joy] = address == joy_port;
		sel_next[sel_dma_master] = port_match(address, dma_master_base, dma_master_ign);
		sel_next[sel_dma_page] = port_match(address, dma_page_base, dma_page_ign);
		sel_next[sel_dma_slave] = port_match(address, dma_slave_base, dma_slave_ign);
		sel_next[sel_pic_master] = port_match(address, pic_master_base, pic_ign);
		sel_next[sel_pic_slave] = port_match(address, pic_slave_base, pic_ign);
		sel_next[sel_pit] = port_match(address, pit_base, pit_ign) || address == pit_port_b;
		sel_next[sel_ps2_io] = port_match(address, ps2_io_base, ps2_io_ign);
		sel_next[sel_ps2_ctl] = port_match(address, ps2_ctl_base, ps2_ctl_ign);
		sel_next[sel_rtc] = port_match(address, rtc_base, rtc_ign);
		sel_next[sel_fm] = port_match(address, fm_base, fm_ign);
		sel_next[sel_sb] = port_match(address, sb_base, sb_ign);
		sel_next[sel_uart] = port_match(address, uart_base, uart_ign);
		sel_next[sel_mpu] = port_match(address, mpu_base, mpu_ign);
		sel_next[sel_vga_b] = port_match(address, vga_b_base, vga_ign);
		sel_next[sel_vga_c] = port_match(address, vga_c_base, vga_ign);
		sel_next[sel_vga_d] = port_match(address, vga_d_base, vga_ign);
		sel_next[sel_pci] = address == pci_cfg_addr || address == pci_cfg_data;
		sel_next[sel_sysctl] = address == sysctl_port;
	end

	// disk data ports and the control port are 32-bit wide
	assign io32_next = ((sel_next[sel_hdd0] | sel_next[sel_hdd1]) & ~address[hdd_alt_bit])
		| sel_next[sel_sysctl];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cyc.rd <= 1'b0;
			cyc.wr <= 1'b0;
			cyc.io32 <= 1'b0;
		end else begin
			cyc.rd <= rd;
			cyc.wr <= wr;
			cyc.io32 <= io32_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		cyc.sel <= sel_next;
		cyc.size <= size;
		cyc.wdata <= wdata;
	end

endmodule

// File: hdl/sys_ctl_port.sv
`timescale 1ns/1ps

module sys_ctl_port #(
	parameter bus_types_pkg::syscfg_t SYSCFG_RESET = bus_types_pkg::syscfg_reset_value
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	io_cycle_if.sink               cyc,
	output bus_types_pkg::syscfg_t syscfg
);
	import io_map_pkg::*;
	import bus_types_pkg::*;

	typedef enum logic {
		ctl_armed,
		ctl_released
	} ctl_state_e;

	ctl_state_e state;
	logic       disk_hit;
	logic       cfg_write;

	assign disk_hit = cyc.sel[sel_hdd0] | cyc.sel[sel_hdd1] | cyc.sel[sel_floppy];

	// keyed word write to the control port
	assign cfg_write = cyc.wr && cyc.sel[sel_sysctl]
		&& cyc.size == syscfg_write_size && cyc.wdata[15:8] == syscfg_key;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg <= SYSCFG_RESET;
			state <= ctl_armed;
		end else if (state == ctl_armed && disk_hit) begin
			syscfg <= '0; // first boot-time disk access drops the default
			state <= ctl_released;
		end else if (cfg_write) begin
			syscfg <= cyc.wdata[7:0];
			state <= ctl_released;
		end
	end

endmodule

// File: hdl/io_read_mux.sv
`timescale 1ns/1ps

module io_read_mux (
	io_cycle_if.sink                cyc,
	input  bus_types_pkg::io_data_t hdd0_rdata,
	input  bus_types_pkg::io_data_t hdd1_rdata,
	input  bus_types_pkg::io_data_t pci_rdata,
	input  bus_types_pkg::io_byte_t floppy_rdata,
	input  bus_types_pkg::io_byte_t dma_rdata,
	input  bus_types_pkg::io_byte_t pic_rdata,
	input  bus_types_pkg::io_byte_t pit_rdata,
	input  bus_types_pkg::io_byte_t ps2_rdata,
	input  bus_types_pkg::io_byte_t rtc_rdata,
	input  bus_types_pkg::io_byte_t sound_rdata,
	input  bus_types_pkg::io_byte_t uart_rdata,
	input  bus_types_pkg::io_byte_t vga_rdata,
	input  bus_types_pkg::io_byte_t joy_rdata,
	output bus_types_pkg::io_data_t rdata,
	output logic                    io32
);
	import io_map_pkg::*;
	import bus_types_pkg::*;

	io_byte_t rdata8;

	always_comb begin
		if (cyc.sel[sel_floppy])
			rdata8 = floppy_rdata;
		else if (cyc.sel[sel_dma_master] | cyc.sel[sel_dma_page] | cyc.sel[sel_dma_slave])
			rdata8 = dma_rdata;
		else if (cyc.sel[sel_pic_master] | cyc.sel[sel_pic_slave])
			rdata8 = pic_rdata;
		else if (cyc.sel[sel_pit])
			rdata8 = pit_rdata;
		else if (cyc.sel[sel_ps2_io] | cyc.sel[sel_ps2_ctl])
			rdata8 = ps2_rdata;
		else if (cyc.sel[sel_rtc])
			rdata8 = rtc_rdata;
		else if (cyc.sel[sel_sb] | cyc.sel[sel_fm])
			rdata8 = sound_rdata;
		else if (cyc.sel[sel_uart] | cyc.sel[sel_mpu])
			rdata8 = uart_rdata;
		else if (cyc.sel[sel_vga_b] | cyc.sel[sel_vga_c] | cyc.sel[sel_vga_d])
			rdata8 = vga_rdata;
		else if (cyc.sel[sel_joy])
			rdata8 = joy_rdata;
		else
			rdata8 = 8'hFF; // floating bus
	end

	// word devices first, 3F6 lands on hdd0 not floppy
	always_comb begin
		if (cyc.sel[sel_hdd0])
			rdata = hdd0_rdata;
		else if (cyc.sel[sel_hdd1])
			rdata = hdd1_rdata;
		else if (cyc.sel[sel_pci])
			rdata = pci_rdata;
		else
			rdata = {24'h000000, rdata8};
	end

	assign io32 = cyc.io32;

endmodule

// File: hdl/io_hub.sv
`timescale 1ns/1ps

module io_hub #(
	parameter bus_types_pkg::syscfg_t SYSCFG_RESET = bus_types_pkg::syscfg_reset_value
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	input  io_map_pkg::io_addr_t    bus_address,
	input  logic                    bus_read,
	input  logic                    bus_write,
	input  bus_types_pkg::io_size_t bus_datasize,
	input  bus_types_pkg::io_data_t bus_writedata,

	input  bus_types_pkg::io_data_t hdd0_rdata,
	input  bus_types_pkg::io_data_t hdd1_rdata,
	input  bus_types_pkg::io_data_t pci_rdata,
	input  bus_types_pkg::io_byte_t floppy_rdata,
	input  bus_types_pkg::io_byte_t dma_rdata,
	input  bus_types_pkg::io_byte_t pic_rdata,
	input  bus_types_pkg::io_byte_t pit_rdata,
	input  bus_types_pkg::io_byte_t ps2_rdata,
	input  bus_types_pkg::io_byte_t rtc_rdata,
	input  bus_types_pkg::io_byte_t sound_rdata,
	input  bus_types_pkg::io_byte_t uart_rdata,
	input  bus_types_pkg::io_byte_t vga_rdata,
	input  bus_types_pkg::io_byte_t joy_rdata,

	output io_map_pkg::dev_sel_t    dev_rd,
	output io_map_pkg::dev_sel_t    dev_wr,
	output bus_types_pkg::io_data_t bus_readdata,
	output logic                    bus_io32,
	output bus_types_pkg::syscfg_t  syscfg
);

	io_cycle_if cyc ();

	io_port_decode u_io_port_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.address (bus_address),
		.rd      (bus_read),
		.wr      (bus_write),
		.size    (bus_datasize),
		.wdata   (bus_writedata),
		.cyc     (cyc.source)
	);

	sys_ctl_port #(
		.SYSCFG_RESET (SYSCFG_RESET)
	) u_sys_ctl_port (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cyc     (cyc.sink),
		.syscfg  (syscfg)
	);

	io_read_mux u_io_read_mux (
		.cyc          (cyc.sink),
		.hdd0_rdata   (hdd0_rdata),
		.hdd1_rdata   (hdd1_rdata),
		.pci_rdata    (pci_rdata),
		.floppy_rdata (floppy_rdata),
		.dma_rdata    (dma_rdata),
		.pic_rdata    (pic_rdata),
		.pit_rdata    (pit_rdata),
		.ps2_rdata    (ps2_rdata),
		.rtc_rdata    (rtc_rdata),
		.sound_rdata  (sound_rdata),
		.uart_rdata   (uart_rdata),
		.vga_rdata    (vga_rdata),
		.joy_rdata    (joy_rdata),
		.rdata        (bus_readdata),
		.io32         (bus_io32)
	);

	// per-device strobes
	assign dev_rd = cyc.rd ? cyc.sel : '0;
	assign dev_wr = cyc.wr ? cyc.sel : '0;

endmodule

// File: dv/io_hub_tb.sv
`timescale 1ns/1ps

module io_hub_tb;
	import io_map_pkg::*;
	import bus_types_pkg::*;

	typedef struct {
		io_addr_t addr;
		logic     wr;
		io_size_t size;
		io_data_t wdata;
		dev_sel_t mask;
		io_data_t rdata;
		logic     io32;
		syscfg_t  cfg;
	} row_t;

	localparam io_data_t hdd0_val = 32'hD0D0_0001;
	localparam io_data_t hdd1_val = 32'hD1D1_0002;
	localparam io_data_t pci_val  = 32'hCFCF_0003;
	localparam int       max_wait = 8;

	logic     clk_sys = 1'b0;
	logic     reset = 1'b1;
	io_addr_t bus_address = 16'h8888; // live cycle held through reset
	logic     bus_read = 1'b1;
	logic     bus_write = 1'b1;
	io_size_t bus_datasize = '0;
	io_data_t bus_writedata = '0;
	dev_sel_t dev_rd;
	dev_sel_t dev_wr;
	io_data_t bus_readdata;
	logic     bus_io32;
	syscfg_t  syscfg;
	row_t     rows[$];
	integer   seed = 32'h81268c8c;

	io_hub u_io_hub (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus_address   (bus_address),
		.bus_read      (bus_read),
		.bus_write     (bus_write),
		.bus_datasize  (bus_datasize),
		.bus_writedata (bus_writedata),
		.hdd0_rdata    (hdd0_val),
		.hdd1_rdata    (hdd1_val),
		.pci_rdata     (pci_val),
		.floppy_rdata  (8'h3F),
		.dma_rdata     (8'hD4),
		.pic_rdata     (8'h21),
		.pit_rdata     (8'h43),
		.ps2_rdata     (8'h64),
		.rtc_rdata     (8'h71),
		.sound_rdata   (8'h5B),
		.uart_rdata    (8'hF8),
		.vga_rdata     (8'hC3),
		.joy_rdata     (8'h02),
		.dev_rd        (dev_rd),
		.dev_wr        (dev_wr),
		.bus_readdata  (bus_readdata),
		.bus_io32      (bus_io32),
		.syscfg        (syscfg)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic dev_sel_t bit_of(int idx);
		return dev_sel_t'(1) << idx;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic add_row(input io_addr_t addr, input logic wr, input io_size_t size,
		input io_data_t wdata, input dev_sel_t mask, input io_data_t rdata, input logic io32,
		input syscfg_t cfg);
		row_t r;
		r = '{addr, wr, size, wdata, mask, rdata, io32, cfg};
		rows.push_back(r);
	endtask

	task automatic fill_table();
		// control port first, while still armed
		add_row(16'h8888, 1, 2, 32'h0000A25C, bit_of(sel_sysctl), 32'hFF, 1, 8'hA2); // bad key
		add_row(16'h8888, 1, 1, 32'h0000A15C, bit_of(sel_sysctl), 32'hFF, 1, 8'hA2); // bad size
		add_row(16'h03F2, 0, 1, 0, bit_of(sel_floppy), 32'h3F, 0, 8'h00);
		add_row(16'h8888, 1, 2, 32'h0000A15C, bit_of(sel_sysctl), 32'hFF, 1, 8'h5C);
		add_row(16'h01F0, 1, 4, 0, bit_of(sel_hdd0), hdd0_val, 1, 8'h5C);
		add_row(16'h01F7, 0, 1, 0, bit_of(sel_hdd0), hdd0_val, 1, 8'h5C);
		add_row(16'h03F6, 0, 1, 0, bit_of(sel_hdd0) | bit_of(sel_floppy), hdd0_val, 0, 8'h5C);
		add_row(16'h0170, 1, 4, 0, bit_of(sel_hdd1), hdd1_val, 1, 8'h5C);
		add_row(16'h0376, 0, 1, 0, bit_of(sel_hdd1), hdd1_val, 0, 8'h5C);
		add_row(16'h0201, 0, 1, 0, bit_of(sel_joy), 32'h02, 0, 8'h5C);
		add_row(16'h03F0, 1, 1, 0, bit_of(sel_floppy), 32'h3F, 0, 8'h5C);
		add_row(16'h00C0, 0, 1, 0, bit_of(sel_dma_master), 32'hD4, 0, 8'h5C);
		add_row(16'h0080, 1, 1, 0, bit_of(sel_dma_page), 32'hD4, 0, 8'h5C);
		add_row(16'h000F, 0, 1, 0, bit_of(sel_dma_slave), 32'hD4, 0, 8'h5C);
		add_row(16'h0021, 0, 1, 0, bit_of(sel_pic_master), 32'h21, 0, 8'h5C);
		add_row(16'h00A1, 1, 1, 0, bit_of(sel_pic_slave), 32'h21, 0, 8'h5C);
		add_row(16'h0040, 0, 1, 0, bit_of(sel_pit), 32'h43, 0, 8'h5C);
		add_row(16'h0061, 0, 1, 0, bit_of(sel_pit) | bit_of(sel_ps2_io), 32'h43, 0, 8'h5C);
		add_row(16'h0064, 0, 1, 0, bit_of(sel_ps2_io), 32'h64, 0, 8'h5C);
		add_row(16'h0090, 1, 1, 0, bit_of(sel_ps2_ctl), 32'h64, 0, 8'h5C);
		add_row(16'h0070, 0, 1, 0, bit_of(sel_rtc), 32'h71, 0, 8'h5C);
		add_row(16'h0388, 0, 1, 0, bit_of(sel_fm), 32'h5B, 0, 8'h5C);
		add_row(16'h0220, 1, 1, 0, bit_of(sel_sb), 32'h5B, 0, 8'h5C);
		add_row(16'h03F8, 0, 1, 0, bit_of(sel_uart), 32'hF8, 0, 8'h5C);
		add_row(16'h0331, 0, 1, 0, bit_of(sel_mpu), 32'hF8, 0, 8'h5C);
		add_row(16'h03B4, 0, 1, 0, bit_of(sel_vga_b), 32'hC3, 0, 8'h5C);
		add_row(16'h03C5, 1, 1, 0, bit_of(sel_vga_c), 32'hC3, 0, 8'h5C);
		add_row(16'h03DA, 0, 1, 0, bit_of(sel_vga_d), 32'hC3, 0, 8'h5C);
		add_row(16'h0CF8, 1, 4, 0, bit_of(sel_pci), pci_val, 0, 8'h5C);
		add_row(16'h0CFC, 0, 4, 0, bit_of(sel_pci), pci_val, 0, 8'h5C);
		add_row(16'h8888, 0, 2, 0, bit_of(sel_sysctl), 32'hFF, 1, 8'h5C);
		add_row(16'h0300, 0, 1, 0, '0, 32'hFF, 0, 8'h5C); // unmapped
	endtask

	task automatic wait_edges(input int n);
		for (int k = 0; k < n; k++) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic apply_row(input int i);
		row_t r;
		string tag;
		int n;
		syscfg_t prev_cfg;
		r = rows[i];
		tag = $sformatf("row %0d port %h", i, r.addr);
		n = 0;
		prev_cfg = (i == 0) ? 8'hA2 : rows[i - 1].cfg;
		@(posedge clk_sys);
		bus_address <= r.addr;
		bus_read <= ~r.wr;
		bus_write <= r.wr;
		bus_datasize <= r.size;
		bus_writedata <= (r.addr == sysctl_port) ? r.wdata : $random(seed);
		if (r.mask == '0) begin
			@(posedge clk_sys);
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			@(negedge clk_sys);
		end else begin
			while ((dev_rd | dev_wr) == '0) begin
				@(posedge clk_sys);
				bus_read <= 1'b0;
				bus_write <= 1'b0;
				@(negedge clk_sys);
				n++;
				if (n > max_wait) begin
					$display("timeout waiting for a device strobe at %s", tag);
					$display("Some tests failed");
					$fatal(1);
				end
			end
			compare({tag, " latency"}, 1, n);
		end
		compare({tag, " dev_wr"}, r.wr ? r.mask : '0, dev_wr);
		compare({tag, " dev_rd"}, r.wr ? '0 : r.mask, dev_rd);
		compare({tag, " readdata"}, r.rdata, bus_readdata);
		compare({tag, " io32"}, r.io32, bus_io32);
		compare({tag, " syscfg early"}, prev_cfg, syscfg);
		wait_edges(1);
		@(negedge clk_sys);
		compare({tag, " syscfg"}, r.cfg, syscfg);
	endtask

	initial begin
		fill_table();
		wait_edges(10);
		reset <= 1'b0;
		bus_read <= 1'b0;
		bus_write <= 1'b0;
		@(negedge clk_sys);
		compare("reset syscfg", 8'hA2, syscfg);
		compare("reset io32", 0, bus_io32);
		compare("reset dev_rd", 0, dev_rd);
		compare("reset dev_wr", 0, dev_wr);
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// File: io_hub.f
hdl/io_map_pkg.sv
hdl/bus_types_pkg.sv
hdl/io_cycle_if.sv
hdl/io_port_decode.sv
hdl/sys_ctl_port.sv
hdl/io_read_mux.sv
hdl/io_hub.sv
dv/io_hub_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = io_hub_tb
FILELIST  = io_hub.f
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
